// File: common/log_cfg.svh
// log unit configuration macros: series degree, unit latencies and series coefficients
`ifndef LOG_CFG_SVH
`define LOG_CFG_SVH

`define LOG_DEGREE   8             // highest power kept in the ln(1+u) series
`define MUL_LAT      2             // enabled cycles through fp_mul
`define ADD_LAT      2             // enabled cycles through fp_add
`define LOG_LATENCY  25            // op_x sample to op_q update

// series coefficients for u^2 .. u^8 as ieee single words
`define LOG_COEF_2   32'hBF000000  // -1/2
`define LOG_COEF_3   32'h3EAAAAAB  // 1/3
`define LOG_COEF_4   32'hBE800000  // -1/4
`define LOG_COEF_5   32'h3E4CCCCD  // 1/5
`define LOG_COEF_6   32'hBE2AAAAB  // -1/6
`define LOG_COEF_7   32'h3E124925  // 1/7
`define LOG_COEF_8   32'hBE000000  // -1/8

`define FP_MINUS_ONE 32'hBF800000

`endif

// File: common/log_pkg.sv
// log unit package: exception tag enum, ieee single struct and tagged float struct
`default_nettype none

package log_pkg;

  // exception tag carried in front of every internal operand
  typedef enum logic [1:0] {
    EXC_ZERO   = 2'b00,
    EXC_NORMAL = 2'b01,
    EXC_INF    = 2'b10,
    EXC_NAN    = 2'b11
  } exc_e;

  // plain ieee-754 single precision word
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] fraction;
  } ieee_t;

  // 34 bit internal operand
  typedef struct packed {
    exc_e  exc;
    ieee_t ieee;
  } fpx_t;

endpackage

`default_nettype wire

// File: hw/fp_mul.sv
// fp_mul: two-stage truncating floating-point multiplier on tagged operands
`default_nettype none
`timescale 1ns/1ps

module fp_mul (
  input  wire logic          clk_95,
  input  wire logic          reset_95,
  input  wire logic          enable,
  input  wire log_pkg::fpx_t a,
  input  wire log_pkg::fpx_t b,
  output log_pkg::fpx_t      p
);

  log_pkg::exc_e     exc_d;
  log_pkg::exc_e     s1_exc;
  logic              s1_sign;
  logic signed [9:0] s1_exp;    // biased and may leave 1..254 before normalizing
  logic [47:0]       s1_prod;
  logic signed [9:0] exp_n;
  logic [22:0]       frac_n;
  log_pkg::fpx_t     res;

  // nan beats inf and inf beats zero but inf times zero gives nan
  always_comb
  begin
    if (a.exc == log_pkg::EXC_NAN || b.exc == log_pkg::EXC_NAN)
      exc_d = log_pkg::EXC_NAN;
    else if ((a.exc == log_pkg::EXC_INF && b.exc == log_pkg::EXC_ZERO) ||
             (a.exc == log_pkg::EXC_ZERO && b.exc == log_pkg::EXC_INF))
      exc_d = log_pkg::EXC_NAN;
    else if (a.exc == log_pkg::EXC_INF || b.exc == log_pkg::EXC_INF)
      exc_d = log_pkg::EXC_INF;
    else if (a.exc == log_pkg::EXC_ZERO || b.exc == log_pkg::EXC_ZERO)
      exc_d = log_pkg::EXC_ZERO;
    else
      exc_d = log_pkg::EXC_NORMAL;
  end

  always_ff @(posedge clk_95 or posedge reset_95)
  begin
    if (reset_95)
    begin
      s1_exc  <= log_pkg::EXC_ZERO;
      s1_sign <= 1'b0;
      s1_exp  <= '0;
      s1_prod <= '0;
    end
    else if (enable)
    begin
      s1_exc  <= exc_d;
      s1_sign <= a.ieee.sign ^ b.ieee.sign;
      s1_exp  <= $signed({2'b00, a.ieee.exponent}) + $signed({2'b00, b.ieee.exponent})
                 - 10'sd127;
      s1_prod <= {1'b1, a.ieee.fraction} * {1'b1, b.ieee.fraction};  // 24x24 mantissas
    end
  end

  // product of two 1.x mantissas is in [1,4) so one bit of shift is enough
  always_comb
  begin
    exp_n    = s1_exp + $signed({9'd0, s1_prod[47]});
    frac_n   = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];  // truncate
    res.exc  = s1_exc;
    res.ieee = {s1_sign, exp_n[7:0], frac_n};
    case (s1_exc)
      log_pkg::EXC_NORMAL:
      begin
        if (exp_n >= 10'sd255)
        begin
          res.exc  = log_pkg::EXC_INF;   // overflow
          res.ieee = {s1_sign, 8'hFF, 23'd0};
        end
        else if (exp_n <= 10'sd0)
        begin
          res.exc  = log_pkg::EXC_ZERO;  // underflow flushes to zero
          res.ieee = {s1_sign, 31'd0};
        end
      end
      log_pkg::EXC_ZERO: res.ieee = {s1_sign, 31'd0};
      log_pkg::EXC_INF:  res.ieee = {s1_sign, 8'hFF, 23'd0};
      default:           res.ieee = {1'b0, 8'hFF, 23'h400000};  // quiet nan
    endcase
  end

  always_ff @(posedge clk_95 or posedge reset_95)
  begin
    if (reset_95)
      p <= '0;
    else if (enable)
      p <= res;
  end

endmodule

`default_nettype wire

// File: hw/fp_add.sv
// fp_add: two-stage truncating floating-point adder with alignment and normalization
`default_nettype none
`timescale 1ns/1ps

module fp_add (
  input  wire logic          clk_95,
  input  wire logic          reset_95,
  input  wire logic          enable,
  input  wire log_pkg::fpx_t a,
  input  wire log_pkg::fpx_t b,
  output log_pkg::fpx_t      s
);

  logic              a_big;
  log_pkg::ieee_t    big;
  log_pkg::ieee_t    small_op;
  log_pkg::exc_e     small_exc;
  logic [7:0]        shift;
  logic [26:0]       small_m;  // 1.x mantissa plus three guard bits
  log_pkg::exc_e     exc_d;
  logic              sign_d;

  log_pkg::exc_e     s1_exc;
  logic              s1_sign;
  logic              s1_sub;
  logic [7:0]        s1_exp;
  logic [26:0]       s1_big;
  logic [26:0]       s1_small;

  logic [27:0]       sum_m;
  logic [4:0]        lz;
  logic [26:0]       norm_m;
  logic signed [9:0] exp_n;
  logic [22:0]       frac_n;
  log_pkg::fpx_t     res;

  always_comb
  begin
    // a zero operand always ends up as the small one
    a_big = (b.exc == log_pkg::EXC_ZERO) ||
            (a.exc != log_pkg::EXC_ZERO &&
             {a.ieee.exponent, a.ieee.fraction} >= {b.ieee.exponent, b.ieee.fraction});
    big       = a_big ? a.ieee : b.ieee;
    small_op  = a_big ? b.ieee : a.ieee;
    small_exc = a_big ? b.exc : a.exc;
    shift     = big.exponent - small_op.exponent;
    small_m   = {1'b1, small_op.fraction, 3'b000} >> shift;  // bits shifted out are lost
    if (small_exc == log_pkg::EXC_ZERO)
      small_m = '0;

    sign_d = big.sign;
    if (a.exc == log_pkg::EXC_NAN || b.exc == log_pkg::EXC_NAN)
      exc_d = log_pkg::EXC_NAN;
    else if (a.exc == log_pkg::EXC_INF && b.exc == log_pkg::EXC_INF)
      exc_d = (a.ieee.sign == b.ieee.sign) ? log_pkg::EXC_INF : log_pkg::EXC_NAN;
    else if (a.exc == log_pkg::EXC_INF || b.exc == log_pkg::EXC_INF)
    begin
      exc_d  = log_pkg::EXC_INF;
      sign_d = (a.exc == log_pkg::EXC_INF) ? a.ieee.sign : b.ieee.sign;
    end
    else if (a.exc == log_pkg::EXC_ZERO && b.exc == log_pkg::EXC_ZERO)
    begin
      exc_d  = log_pkg::EXC_ZERO;
      sign_d = a.ieee.sign & b.ieee.sign;  // -0 only when both are -0
    end
    else
      exc_d = log_pkg::EXC_NORMAL;
  end

  always_ff @(posedge clk_95 or posedge reset_95)
  begin
    if (reset_95)
    begin
      s1_exc   <= log_pkg::EXC_ZERO;
      s1_sign  <= 1'b0;
      s1_sub   <= 1'b0;
      s1_exp   <= '0;
      s1_big   <= '0;
      s1_small <= '0;
    end
    else if (enable)
    begin
      s1_exc   <= exc_d;
      s1_sign  <= sign_d;
      s1_sub   <= a.ieee.sign ^ b.ieee.sign;
      s1_exp   <= big.exponent;
      s1_big   <= {1'b1, big.fraction, 3'b000};
      s1_small <= small_m;
    end
  end

  // big is never below small in magnitude, so the difference stays positive
  always_comb
  begin
    sum_m = s1_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
                   : ({1'b0, s1_big} + {1'b0, s1_small});
    lz = '0;
    for (int i = 0; i < 27; i++)
      if (sum_m[i])
        lz = 5'(26 - i);  // highest set bit wins
    norm_m = sum_m[26:0] << lz;
    if (sum_m[27])
    begin
      exp_n  = {2'b00, s1_exp} + 10'd1;  // carry out
      frac_n = sum_m[26:4];
    end
    else
    begin
      exp_n  = $signed({2'b00, s1_exp}) - $signed({5'd0, lz});
      frac_n = norm_m[25:3];
    end

    res.exc  = s1_exc;
    res.ieee = {s1_sign, exp_n[7:0], frac_n};
    case (s1_exc)
      log_pkg::EXC_NORMAL:
      begin
        if (sum_m == '0)
        begin
          res.exc  = log_pkg::EXC_ZERO;  // exact cancellation gives +0
          res.ieee = '0;
        end
        else if (exp_n >= 10'sd255)
        begin
          res.exc  = log_pkg::EXC_INF;
          res.ieee = {s1_sign, 8'hFF, 23'd0};
        end
        else if (exp_n <= 10'sd0)
        begin
          res.exc  = log_pkg::EXC_ZERO;
          res.ieee = {s1_sign, 31'd0};
        end
      end
      log_pkg::EXC_ZERO: res.ieee = {s1_sign, 31'd0};
      log_pkg::EXC_INF:  res.ieee = {s1_sign, 8'hFF, 23'd0};
      default:           res.ieee = {1'b0, 8'hFF, 23'h400000};
    endcase
  end

  always_ff @(posedge clk_95 or posedge reset_95)
  begin
    if (reset_95)
      s <= '0;
    else if (enable)
      s <= res;
  end

endmodule

`default_nettype wire

// File: hw/fp_delay.sv
// fp_delay: enable-gated delay line of tagged floats for pipeline alignment
`default_nettype none
`timescale 1ns/1ps

module fp_delay #(
  parameter int DEPTH = 1
) (
  input  wire logic          clk_95,
  input  wire logic          reset_95,
  input  wire logic          enable,
  input  wire log_pkg::fpx_t d,
  output log_pkg::fpx_t      q
);

  if (DEPTH == 0)
  begin : g_pass
    assign q = d;  // operand already on time
  end
  else
  begin : g_shift
    log_pkg::fpx_t stage [DEPTH];

    always_ff @(posedge clk_95 or posedge reset_95)
    begin
      if (reset_95)
      begin
        for (int i = 0; i < DEPTH; i++)
          stage[i] <= '0;
      end
      else if (enable)
      begin
        stage[0] <= d;
        for (int i = 1; i < DEPTH; i++)
          stage[i] <= stage[i-1];
      end
    end

    assign q = stage[DEPTH-1];
  end

endmodule

`default_nettype wire

// File: series/power_chain.sv
// power_chain: forms u = x - 1 and u^2 .. u^8, all aligned to one output time
`default_nettype none
`timescale 1ns/1ps
`include "log_cfg.svh"

module power_chain (
  input  wire logic                              clk_95,
  input  wire logic                              reset_95,
  input  wire logic                              enable,
  input  wire log_pkg::fpx_t                     x,
  output wire log_pkg::fpx_t [1:`LOG_DEGREE]     pow
);

  // u^k is ready at ADD_LAT + MUL_LAT*(k-1), the last power sets the common time
  localparam int CHAIN_LAT = `ADD_LAT + `MUL_LAT * (`LOG_DEGREE - 1);
  localparam log_pkg::fpx_t MINUS_ONE = {log_pkg::EXC_NORMAL, `FP_MINUS_ONE};

  wire log_pkg::fpx_t [1:`LOG_DEGREE] raw;    // each power at its own time
  wire log_pkg::fpx_t [2:`LOG_DEGREE] u_tap;  // copy of u lined up with raw[k-1]

  fp_add u_sub (
    .clk_95   (clk_95),
    .reset_95 (reset_95),
    .enable   (enable),
    .a        (x),
    .b        (MINUS_ONE),
    .s        (raw[1])
  );

  for (genvar k = 2; k <= `LOG_DEGREE; k++)
  begin : g_pow
    fp_delay #(.DEPTH(`MUL_LAT * (k - 2))) u_tap_dly (
      .clk_95   (clk_95),
      .reset_95 (reset_95),
      .enable   (enable),
      .d        (raw[1]),
      .q        (u_tap[k])
    );

    // u^k = u^(k-1) * u
    fp_mul u_mul (
      .clk_95   (clk_95),
      .reset_95 (reset_95),
      .enable   (enable),
      .a        (raw[k-1]),
      .b        (u_tap[k]),
      .p        (raw[k])
    );
  end

  for (genvar k = 1; k <= `LOG_DEGREE; k++)
  begin : g_align
    fp_delay #(.DEPTH(CHAIN_LAT - `ADD_LAT - `MUL_LAT * (k - 1))) u_align (
      .clk_95   (clk_95),
      .reset_95 (reset_95),
      .enable   (enable),
      .d        (raw[k]),
      .q        (pow[k])
    );
  end

endmodule

`default_nettype wire

// File: series/term_sum.sv
// term_sum: scales u^2 .. u^8 by the series coefficients and sums all terms in an adder tree
`default_nettype none
`timescale 1ns/1ps
`include "log_cfg.svh"

module term_sum (
  input  wire logic                          clk_95,
  input  wire logic                          reset_95,
  input  wire logic                          enable,
  input  wire log_pkg::fpx_t [1:`LOG_DEGREE] pow,
  output log_pkg::fpx_t                      sum
);

  localparam int TERMS = `LOG_DEGREE;  // eight leaves for u and the seven scaled powers
  localparam logic [31:0] COEF [2:`LOG_DEGREE] = '{
    `LOG_COEF_2, `LOG_COEF_3, `LOG_COEF_4, `LOG_COEF_5,
    `LOG_COEF_6, `LOG_COEF_7, `LOG_COEF_8
  };

  // nodes 0..TERMS-1 are the leaves and node TERMS+i is adder i with the root last
  wire log_pkg::fpx_t [0:2*TERMS-2] node;

  // u has coefficient 1 and only waits for the products
  fp_delay #(.DEPTH(`MUL_LAT)) u_u_dly (
    .clk_95   (clk_95),
    .reset_95 (reset_95),
    .enable   (enable),
    .d        (pow[1]),
    .q        (node[0])
  );

  for (genvar k = 2; k <= `LOG_DEGREE; k++)
  begin : g_prod
    fp_mul u_mul (
      .clk_95   (clk_95),
      .reset_95 (reset_95),
      .enable   (enable),
      .a        (pow[k]),
      .b        ({log_pkg::EXC_NORMAL, COEF[k]}),
      .p        (node[k-1])
    );
  end

  // three levels of ADD_LAT each for eight leaves
  for (genvar i = 0; i < TERMS - 1; i++)
  begin : g_tree
    fp_add u_add (
      .clk_95   (clk_95),
      .reset_95 (reset_95),
      .enable   (enable),
      .a        (node[2*i]),
      .b        (node[2*i+1]),
      .s        (node[TERMS+i])
    );
  end

  assign sum = node[2*TERMS-2];

endmodule

`default_nettype wire

// File: hw/log_unit.sv
// log_unit: top level with input tagging, valid pipeline and the op_q, done and error register
`default_nettype none
`timescale 1ns/1ps
`include "log_cfg.svh"

module log_unit (
  input  wire logic           clk_95,
  input  wire logic           reset_95,
  input  wire logic           enable,
  input  wire log_pkg::ieee_t op_x,
  output log_pkg::ieee_t      op_q,
  output logic                done,
  output logic                error
);

  log_pkg::fpx_t                      x_tag;
  wire log_pkg::fpx_t [1:`LOG_DEGREE] pow;
  log_pkg::fpx_t                      sum;
  logic [`LOG_LATENCY-2:0]            valid_sr;  // one bit per sample in flight

  // exponent all ones is inf or nan, zero exponent is flushed to zero
  always_comb
  begin
    x_tag.ieee = op_x;
    if (op_x.exponent == 8'hFF)
      x_tag.exc = (op_x.fraction == '0) ? log_pkg::EXC_INF : log_pkg::EXC_NAN;
    else if (op_x.exponent == 8'h00)
      x_tag.exc = log_pkg::EXC_ZERO;
    else
      x_tag.exc = log_pkg::EXC_NORMAL;
  end

  power_chain u_power_chain (
    .clk_95   (clk_95),
    .reset_95 (reset_95),
    .enable   (enable),
    .x        (x_tag),
    .pow      (pow)
  );

  term_sum u_term_sum (
    .clk_95   (clk_95),
    .reset_95 (reset_95),
    .enable   (enable),
    .pow      (pow),
    .sum      (sum)
  );

  always_ff @(posedge clk_95 or posedge reset_95)
  begin
    if (reset_95)
    begin
      valid_sr <= '0;
      op_q     <= '0;
      done     <= 1'b0;
      error    <= 1'b0;
    end
    else if (enable)
    begin
      valid_sr <= {valid_sr[`LOG_LATENCY-3:0], 1'b1};  // every enabled cycle is a sample
      if (!valid_sr[`LOG_LATENCY-2])
      begin
        op_q  <= '0;  // pipeline fill
        done  <= 1'b0;
        error <= 1'b0;
      end
      else if (sum.exc == log_pkg::EXC_INF || sum.exc == log_pkg::EXC_NAN)
      begin
        op_q  <= '0;
        done  <= 1'b0;
        error <= 1'b1;
      end
      else
      begin
        op_q  <= sum.ieee;
        done  <= 1'b1;
        error <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/log_unit_chk.sv
// log_unit_chk: concurrent output assertions for log_unit and their bind
`default_nettype none
`timescale 1ns/1ps

module log_unit_chk (
  input wire logic           clk_95,
  input wire logic           reset_95,
  input wire logic           enable,
  input wire log_pkg::ieee_t op_q,
  input wire logic           done,
  input wire logic           error
);

  a_excl: assert property (@(posedge clk_95) disable iff (reset_95) !(done && error))
    else $error("done and error are high together");

  a_err_zero: assert property (@(posedge clk_95) disable iff (reset_95)
                               error |-> (op_q == '0))
    else $error("op_q is not zero while error is high");

  a_after_reset: assert property (@(posedge clk_95) $fell(reset_95) |-> (!done && !error))
    else $error("done or error high right after reset");

  // a frozen edge leaves every output as it was
  a_stall: assert property (@(posedge clk_95) disable iff (reset_95)
                            !enable |=> ($stable(op_q) && $stable(done) && $stable(error)))
    else $error("outputs changed across a cycle with enable low");

endmodule

bind log_unit log_unit_chk u_chk (
  .clk_95   (clk_95),
  .reset_95 (reset_95),
  .enable   (enable),
  .op_q     (op_q),
  .done     (done),
  .error    (error)
);

`default_nettype wire

// File: verification/log_unit_tb.sv
// log_unit_tb: clock, reset, directed tests, series reference model and closing report
`default_nettype none
`timescale 1ns/1ps
`include "log_cfg.svh"

module log_unit_tb;

  localparam real            TOL = 1.0 / 65536.0;  // 2^-16
  localparam log_pkg::ieee_t ONE = 32'h3F800000;

  logic           clk_95;
  logic           reset_95;
  logic           enable;
  log_pkg::ieee_t op_x;
  log_pkg::ieee_t op_q;
  logic           done;
  logic           error;

  logic           trk;        // sample belongs to a test, not idle filler
  string          test_name;
  int             errors;
  int             checks;
  int             pending;    // tracked samples still in flight
  bit             timed_out;
  int             en_count;   // enabled edges since reset
  logic           last_en;
  log_pkg::ieee_t prev_q;
  logic           prev_done;
  logic           prev_error;

  // expected results in issue order
  real   exp_q[$];
  int    edge_q[$];
  int    kind_q[$];  // 0 near, 1 exact zero, 2 exception
  bit    trk_q[$];
  string name_q[$];

  log_unit dut (
    .clk_95   (clk_95),
    .reset_95 (reset_95),
    .enable   (enable),
    .op_x     (op_x),
    .op_q     (op_q),
    .done     (done),
    .error    (error)
  );

  initial
  begin
    clk_95 = 1'b0;
    forever #5 clk_95 = ~clk_95;
  end

  function automatic real to_real(log_pkg::ieee_t w);
    real mag;
    if (w.exponent == 8'h00)
      return 0.0;  // zero and flushed subnormals
    mag = (1.0 + real'(w.fraction) / 8388608.0) * (2.0 ** (real'(w.exponent) - 127.0));
    return w.sign ? -mag : mag;
  endfunction

  // ln(1+u) truncated after the u^8 term
  function automatic real series_ref(log_pkg::ieee_t x);
    real u;
    real p;
    real s;
    u = to_real(x) - 1.0;
    p = 1.0;
    s = 0.0;
    for (int k = 1; k <= `LOG_DEGREE; k++)
    begin
      p = p * u;
      s = s + ((k % 2 == 1) ? p : -p) / real'(k);
    end
    return s;
  endfunction

  function automatic int kind_of(log_pkg::ieee_t x);
    if (x.exponent == 8'hFF)
      return 2;
    else if (x == ONE)
      return 1;
    return 0;
  endfunction

  function automatic log_pkg::ieee_t rand_near_one();
    log_pkg::ieee_t w;
    w.sign = 1'b0;
    if ($urandom % 2 == 0)
    begin
      w.exponent = 8'd126;                         // [0.75, 1)
      w.fraction = 23'h400000 | 23'($urandom);
    end
    else
    begin
      w.exponent = 8'd127;                         // [1, 1.25)
      w.fraction = 23'($urandom) & 23'h1FFFFF;
    end
    return w;
  endfunction

  task automatic check_word(string name, log_pkg::ieee_t exp_w, log_pkg::ieee_t act_w);
    checks++;
    if (act_w !== exp_w)
    begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp_w, act_w);
    end
  endtask

  task automatic check_near(string name, real exp_r, log_pkg::ieee_t act_w);
    real act_r;
    real diff;
    real size;
    checks++;
    act_r = to_real(act_w);
    diff  = (exp_r > act_r) ? exp_r - act_r : act_r - exp_r;
    size  = (act_r < 0.0) ? -act_r : act_r;
    if (diff > TOL && diff > TOL * size)
    begin
      errors++;
      $display("[ERROR] %s expected %g actual %g (%h)", name, exp_r, act_r, act_w);
    end
  endtask

  task automatic check_flags(string name, logic exp_done, logic exp_error,
                             logic act_done, logic act_error);
    checks++;
    if (act_done !== exp_done || act_error !== exp_error)
    begin
      errors++;
      $display("[ERROR] %s expected done %b error %b actual done %b error %b",
               name, exp_done, exp_error, act_done, act_error);
    end
  endtask

  task automatic take_result();
    string nm;
    int    kind;
    real   e;
    bit    t;
    nm   = name_q.pop_front();
    kind = kind_q.pop_front();
    void'(edge_q.pop_front());
    e    = exp_q.pop_front();
    t    = trk_q.pop_front();
    case (kind)
      2:
      begin
        check_flags(nm, 1'b0, 1'b1, done, error);
        check_word(nm, '0, op_q);
      end
      1:
      begin
        check_flags(nm, 1'b1, 1'b0, done, error);
        check_word(nm, '0, op_q);  // exactly +0
      end
      default:
      begin
        check_flags(nm, 1'b1, 1'b0, done, error);
        check_near(nm, e, op_q);
      end
    endcase
    if (t)
      pending--;
  endtask

  // outputs settle after the rising edge, inputs were set at the same edge
  always @(negedge clk_95)
  begin
    if (!reset_95)
    begin
      if (last_en)
      begin
        en_count++;
        // a sample taken at edge n shows up at edge n + LOG_LATENCY - 1
        if (edge_q.size() > 0 && edge_q[0] + `LOG_LATENCY - 1 == en_count)
          take_result();
        else if (done || error)
        begin
          errors++;
          $display("a result came out with no sample due, test %s", test_name);
        end
      end
      else
      begin
        check_word({test_name, " hold"}, prev_q, op_q);
        check_flags({test_name, " hold"}, prev_done, prev_error, done, error);
      end
      if (enable)
      begin
        exp_q.push_back(series_ref(op_x));
        edge_q.push_back(en_count + 1);
        kind_q.push_back(kind_of(op_x));
        trk_q.push_back(trk);
        name_q.push_back(test_name);
        if (trk)
          pending++;
      end
      last_en = enable;
    end
    prev_q     = op_q;
    prev_done  = done;
    prev_error = error;
  end

  task automatic send(log_pkg::ieee_t v);
    @(posedge clk_95);
    op_x   <= v;
    enable <= 1'b1;
    trk    <= 1'b1;
  endtask

  task automatic idle();
    @(posedge clk_95);
    op_x   <= ONE;  // filler gives exact zero
    enable <= 1'b1;
    trk    <= 1'b0;
  endtask

  task automatic stall(int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk_95);
      enable <= 1'b0;
    end
  endtask

  task automatic wait_drain(int limit);
    int cycles;
    cycles = 0;
    while (pending != 0 && cycles < limit)
    begin
      @(posedge clk_95);
      cycles++;
    end
    if (pending != 0)
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout in test %s, %0d results never came out", test_name, pending);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    check_word(test_name, '0, op_q);
    check_flags(test_name, 1'b0, 1'b0, done, error);
  endtask

  task automatic test_zero();
    test_name = "zero";
    send(ONE);
    idle();
    wait_drain(100);
  endtask

  task automatic test_stream();
    test_name = "stream";
    repeat (40) send(rand_near_one());
    idle();
    wait_drain(100);
  endtask

  task automatic test_exceptions();
    test_name = "exceptions";
    send(rand_near_one());
    send(32'h7F800000);  // +inf
    send(rand_near_one());
    send(32'h7FC00000);  // nan
    send(rand_near_one());
    send(32'hFF800000);  // -inf
    send(rand_near_one());
    idle();
    wait_drain(100);
  endtask

  task automatic test_stall();
    test_name = "stall";
    for (int i = 0; i < 30; i++)
    begin
      send(rand_near_one());
      if ($urandom % 4 == 0)
        stall(int'($urandom % 3) + 1);
    end
    stall(3);  // freeze with the stream in flight
    idle();
    wait_drain(200);
  endtask

  initial
  begin
    void'($urandom(32'h0a0f5f82));
    errors     = 0;
    checks     = 0;
    pending    = 0;
    timed_out  = 1'b0;
    en_count   = 0;
    last_en    = 1'b0;
    prev_q     = '0;
    prev_done  = 1'b0;
    prev_error = 1'b0;
    test_name  = "fill";
    reset_95   = 1'b1;
    enable     = 1'b0;
    op_x       = ONE;
    trk        = 1'b0;
    repeat (5) @(posedge clk_95);
    reset_95 <= 1'b0;
    @(negedge clk_95);
    test_reset();
    test_zero();
    if (!timed_out)
      test_stream();
    if (!timed_out)
      test_exceptions();
    if (!timed_out)
      test_stall();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0 && !timed_out)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/log_pkg.sv
hw/fp_mul.sv
hw/fp_add.sv
hw/fp_delay.sv
series/power_chain.sv
series/term_sum.sv
hw/log_unit.sv
verification/log_unit_chk.sv
verification/log_unit_tb.sv

// File: run.sh
#!/bin/sh
# builds the log unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module log_unit_tb \
  --Mdir obj_dir \
  -o log_unit_sim

./obj_dir/log_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
